//--- Makefile
TB_TOP = tb_matrix_multiplication
FLIST  = matrix_multiplication.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module matrix_multiplication -f $(FLIST)
	verilator --lint-only --timing --top-module $(TB_TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) \
	  -f $(FLIST) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
  input  logic          clk_mem,
  input  logic          reset,
  input  logic          clear_acc,
  input  mm_pkg::elem_t a_in,
  input  mm_pkg::elem_t b_in,
  output mm_pkg::elem_t a_out,
  output mm_pkg::elem_t b_out,
  output mm_pkg::elem_t acc
);

  mm_pkg::elem_t prod_lo;

  // Only the low byte of the product reaches the sum
  assign prod_lo = a_in * b_in;

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_out <= '0;
      b_out <= '0;
      acc   <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
      // Clear wins over a product arriving in the same cycle
      if (clear_acc) begin
        acc <= '0;
      end else begin
        acc <= acc + prod_lo;
      end
    end
  end

endmodule

//--- matmul_control.sv
`timescale 1ns/1ps

module matmul_control (
  input  logic                          clk_mem,
  input  logic                          reset,
  input  logic                          start_mat_mul,
  output logic                          op_rd_en,
  output logic [mm_pkg::ADDR_WIDTH-1:0] op_addr,
  output logic                          clear_acc,
  output logic                          c_wr_en,
  output logic [mm_pkg::ADDR_WIDTH-1:0] c_wr_row,
  output logic                          done_mat_mul
);

  // Schedule in cycles after start was sampled
  localparam int CNT_W = $clog2(4 * mm_pkg::MAT_SIZE + 3);
  localparam logic [CNT_W-1:0] RD_FIRST = CNT_W'(1);
  localparam logic [CNT_W-1:0] RD_LAST  = CNT_W'(mm_pkg::MAT_SIZE);
  localparam logic [CNT_W-1:0] WR_FIRST = CNT_W'(3 * mm_pkg::MAT_SIZE + 1);
  localparam logic [CNT_W-1:0] WR_LAST  = CNT_W'(4 * mm_pkg::MAT_SIZE);
  localparam logic [CNT_W-1:0] DONE_CYC = CNT_W'(4 * mm_pkg::MAT_SIZE + 2);

  logic                          running;
  logic [CNT_W-1:0]              cnt;
  logic [mm_pkg::ADDR_WIDTH-1:0] rd_ptr;
  logic [mm_pkg::ADDR_WIDTH-1:0] wr_ptr;

  //////////////////////////////
  // Run state and cycle count
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      running <= 1'b0;
      cnt     <= '0;
      rd_ptr  <= '0;
      wr_ptr  <= '0;
    end else begin
      if (!running) begin
        if (start_mat_mul) begin
          running <= 1'b1;
          cnt     <= '0;
        end
      end else if (cnt == DONE_CYC) begin
        running <= 1'b0;
        cnt     <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      // Both pointers wrap back to 0 after a full matrix
      if (op_rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (c_wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Schedule decode
  //////////////////////////////

  assign clear_acc    = running && (cnt == '0);
  assign op_rd_en     = running && (cnt >= RD_FIRST) && (cnt <= RD_LAST);
  assign c_wr_en      = running && (cnt >= WR_FIRST) && (cnt <= WR_LAST);
  assign done_mat_mul = running && (cnt == DONE_CYC);
  assign op_addr      = rd_ptr;
  assign c_wr_row     = wr_ptr;

  // Host waits for done before the next start
  start_while_running_a: assert property (
    @(posedge clk_mem) disable iff (reset)
    start_mat_mul |-> !running
  );

  done_single_pulse_a: assert property (
    @(posedge clk_mem) disable iff (reset)
    done_mat_mul |=> !done_mat_mul
  );

endmodule

//--- matrix_multiplication.f
mm_pkg.sv
mac_pe.sv
systolic_array.sv
operand_bank.sv
result_bank.sv
matmul_control.sv
matrix_multiplication.sv
tb_matrix_multiplication.sv

//--- matrix_multiplication.sv
`timescale 1ns/1ps

module matrix_multiplication (
  input  logic                            clk_mem,
  input  logic                            reset,
  input  logic                            enable_writing_to_mem,
  input  logic                            enable_reading_from_mem,
  input  logic                            we_a,
  input  logic                            we_b,
  input  logic [mm_pkg::ADDR_WIDTH-1:0]   addr_pi,
  input  mm_pkg::vector_t                 data_pi,
  input  logic                            start_mat_mul,
  output mm_pkg::vector_t                 data_from_out_mat,
  output logic                            done_mat_mul
);

  mm_pkg::host_req_t                host_req;
  logic                             op_rd_en;
  logic [mm_pkg::ADDR_WIDTH-1:0]    op_addr;
  logic                             clear_acc;
  logic                             c_wr_en;
  logic [mm_pkg::ADDR_WIDTH-1:0]    c_wr_row;
  mm_pkg::vector_t                  a_col;
  mm_pkg::vector_t                  b_row;
  mm_pkg::result_matrix_t           result;

  //////////////////////////////
  // Host input register
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    host_req.addr <= addr_pi;
    host_req.data <= data_pi;
    if (reset) begin
      host_req.write_a <= 1'b0;
      host_req.write_b <= 1'b0;
      host_req.read_c  <= 1'b0;
    end else begin
      host_req.write_a <= enable_writing_to_mem & we_a;
      host_req.write_b <= enable_writing_to_mem & we_b;
      host_req.read_c  <= enable_reading_from_mem;
    end
  end

  //////////////////////////////
  // Operand memories
  //////////////////////////////

  // A holds one column per word
  operand_bank u_bank_a (
    .clk_mem (clk_mem),
    .reset   (reset),
    .req     (host_req),
    .wr_en   (host_req.write_a),
    .rd_en   (op_rd_en),
    .rd_addr (op_addr),
    .rd_data (a_col)
  );

  // B holds one row per word
  operand_bank u_bank_b (
    .clk_mem (clk_mem),
    .reset   (reset),
    .req     (host_req),
    .wr_en   (host_req.write_b),
    .rd_en   (op_rd_en),
    .rd_addr (op_addr),
    .rd_data (b_row)
  );

  matmul_control u_control (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .op_rd_en      (op_rd_en),
    .op_addr       (op_addr),
    .clear_acc     (clear_acc),
    .c_wr_en       (c_wr_en),
    .c_wr_row      (c_wr_row),
    .done_mat_mul  (done_mat_mul)
  );

  systolic_array u_array (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .clear_acc (clear_acc),
    .a_col     (a_col),
    .b_row     (b_row),
    .result    (result)
  );

  result_bank u_bank_c (
    .clk_mem (clk_mem),
    .reset   (reset),
    .req     (host_req),
    .wr_en   (c_wr_en),
    .wr_row  (c_wr_row),
    .result  (result),
    .rd_data (data_from_out_mat)
  );

endmodule

//--- mm_pkg.sv
package mm_pkg;

  //////////////////////////////
  // Array geometry
  //////////////////////////////

  localparam int MAT_SIZE   = 4;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = $clog2(MAT_SIZE);

  //////////////////////////////
  // Data types
  //////////////////////////////

  // One unsigned matrix element
  typedef logic [DATA_WIDTH-1:0] elem_t;

  // One memory word, element 0 in the low byte
  typedef elem_t [MAT_SIZE-1:0] vector_t;

  // Accumulator contents, indexed [row][column]
  typedef vector_t [MAT_SIZE-1:0] result_matrix_t;

  // Host request after the input register
  typedef struct packed {
    logic                  write_a;
    logic                  write_b;
    logic                  read_c;
    logic [ADDR_WIDTH-1:0] addr;
    vector_t               data;
  } host_req_t;

endpackage

//--- operand_bank.sv
`timescale 1ns/1ps

module operand_bank (
  input  logic                          clk_mem,
  input  logic                          reset,
  input  mm_pkg::host_req_t             req,
  input  logic                          wr_en,
  input  logic                          rd_en,
  input  logic [mm_pkg::ADDR_WIDTH-1:0] rd_addr,
  output mm_pkg::vector_t               rd_data
);

  mm_pkg::vector_t               mem [mm_pkg::MAT_SIZE];
  logic [mm_pkg::ADDR_WIDTH-1:0] addr;

  // Host owns the address while loading
  assign addr = wr_en ? req.addr : rd_addr;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (wr_en) begin
      mem[addr] <= req.data;
    end
  end

  //////////////////////////////
  // Registered read port
  //////////////////////////////

  // Zeros on idle cycles so the array only ever sees real steps
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[addr];
    end else begin
      rd_data <= '0;
    end
  end

  // Loading and streaming share one address, they must not overlap
  load_during_read_a: assert property (
    @(posedge clk_mem) disable iff (reset)
    rd_en |-> !wr_en
  );

endmodule

//--- result_bank.sv
`timescale 1ns/1ps

module result_bank (
  input  logic                          clk_mem,
  input  logic                          reset,
  input  mm_pkg::host_req_t             req,
  input  logic                          wr_en,
  input  logic [mm_pkg::ADDR_WIDTH-1:0] wr_row,
  input  mm_pkg::result_matrix_t        result,
  output mm_pkg::vector_t               rd_data
);

  mm_pkg::vector_t mem [mm_pkg::MAT_SIZE];

  //////////////////////////////
  // Row write from the array
  //////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (wr_en) begin
      mem[wr_row] <= result[wr_row];
    end
  end

  //////////////////////////////
  // Host read port
  //////////////////////////////

  // Second cycle of the two-cycle read latency
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_data <= '0;
    end else if (req.read_c) begin
      rd_data <= mem[req.addr];
    end else begin
      rd_data <= '0;
    end
  end

  // Host reads of C wait until the sequencer is done writing
  read_during_write_a: assert property (
    @(posedge clk_mem) disable iff (reset)
    wr_en |-> !req.read_c
  );

endmodule

//--- systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  logic                   clear_acc,
  input  mm_pkg::vector_t        a_col,
  input  mm_pkg::vector_t        b_row,
  output mm_pkg::result_matrix_t result
);

  // a_link[i][j] enters PE(i,j) from the left, b_link[i][j] from above
  mm_pkg::elem_t a_link [mm_pkg::MAT_SIZE][mm_pkg::MAT_SIZE+1];
  mm_pkg::elem_t b_link [mm_pkg::MAT_SIZE+1][mm_pkg::MAT_SIZE];

  //////////////////////////////
  // Input skew
  //////////////////////////////

  // Lane n delays row n of A and column n of B by n cycles
  for (genvar n = 0; n < mm_pkg::MAT_SIZE; n++) begin : g_skew
    if (n == 0) begin : g_direct
      assign a_link[0][0] = a_col[0];
      assign b_link[0][0] = b_row[0];
    end else begin : g_delay
      mm_pkg::elem_t a_pipe [n];
      mm_pkg::elem_t b_pipe [n];

      always_ff @(posedge clk_mem) begin
        if (reset) begin
          for (int d = 0; d < n; d++) begin
            a_pipe[d] <= '0;
            b_pipe[d] <= '0;
          end
        end else begin
          a_pipe[0] <= a_col[n];
          b_pipe[0] <= b_row[n];
          for (int d = 1; d < n; d++) begin
            a_pipe[d] <= a_pipe[d-1];
            b_pipe[d] <= b_pipe[d-1];
          end
        end
      end

      assign a_link[n][0] = a_pipe[n-1];
      assign b_link[0][n] = b_pipe[n-1];
    end
  end

  //////////////////////////////
  // PE grid
  //////////////////////////////

  // A flows right along a row, B flows down a column
  for (genvar i = 0; i < mm_pkg::MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < mm_pkg::MAT_SIZE; j++) begin : g_col
      mac_pe u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .clear_acc (clear_acc),
        .a_in      (a_link[i][j]),
        .b_in      (b_link[i][j]),
        .a_out     (a_link[i][j+1]),
        .b_out     (b_link[i+1][j]),
        .acc       (result[i][j])
      );
    end
  end

endmodule

//--- tb_matrix_multiplication.sv
`timescale 1ns/1ps

module tb_matrix_multiplication;

  localparam int N           = mm_pkg::MAT_SIZE;
  localparam int RUN_LATENCY = 4 * mm_pkg::MAT_SIZE + 2;
  localparam int DONE_LIMIT  = 2 * RUN_LATENCY;
  // Nine runs of about 40 cycles each plus reset and margin
  localparam int CYCLE_LIMIT = 600;

  logic                          clk_mem = 1'b0;
  logic                          reset;
  logic                          enable_writing_to_mem;
  logic                          enable_reading_from_mem;
  logic                          we_a;
  logic                          we_b;
  logic [mm_pkg::ADDR_WIDTH-1:0] addr_pi;
  mm_pkg::vector_t               data_pi;
  logic                          start_mat_mul;
  mm_pkg::vector_t               data_from_out_mat;
  logic                          done_mat_mul;

  integer     seed = 32'h72d8_450a;
  int         errors = 0;
  int         cycle_count = 0;
  bit         run_active = 1'b0;
  logic [7:0] a_m [N][N];
  logic [7:0] b_m [N][N];

  matrix_multiplication UUT (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .addr_pi                 (addr_pi),
    .data_pi                 (data_pi),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  always #2 clk_mem = ~clk_mem;

  always @(posedge clk_mem) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles, errors %0d",
               CYCLE_LIMIT, errors);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Host port helpers
  //////////////////////////////

  task automatic write_word(input bit to_b, input int addr, input mm_pkg::vector_t word);
    assert (!run_active) else begin
      $display("Host write issued while a run was in progress");
      errors++;
    end
    @(posedge clk_mem);
    enable_writing_to_mem <= 1'b1;
    we_a                  <= !to_b;
    we_b                  <= to_b;
    addr_pi               <= mm_pkg::ADDR_WIDTH'(addr);
    data_pi               <= word;
  endtask

  task automatic end_writes();
    @(posedge clk_mem);
    enable_writing_to_mem <= 1'b0;
    we_a                  <= 1'b0;
    we_b                  <= 1'b0;
  endtask

  // A goes in column by column
  task automatic load_a();
    mm_pkg::vector_t word;
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        word[i] = a_m[i][k];
      end
      write_word(1'b0, k, word);
    end
    end_writes();
  endtask

  // B goes in row by row
  task automatic load_b();
    mm_pkg::vector_t word;
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        word[j] = b_m[k][j];
      end
      write_word(1'b1, k, word);
    end
    end_writes();
  endtask

  // Data is sampled two cycles after the address
  task automatic read_row(input int row, output mm_pkg::vector_t word);
    @(posedge clk_mem);
    enable_reading_from_mem <= 1'b1;
    addr_pi                 <= mm_pkg::ADDR_WIDTH'(row);
    @(posedge clk_mem);
    enable_reading_from_mem <= 1'b0;
    @(posedge clk_mem);
    @(negedge clk_mem);
    word = data_from_out_mat;
  endtask

  task automatic run_multiply(output int latency);
    bit seen;
    @(posedge clk_mem);
    start_mat_mul <= 1'b1;
    run_active = 1'b1;
    @(posedge clk_mem);
    start_mat_mul <= 1'b0;
    seen    = 1'b0;
    latency = 0;
    while (!seen && latency < DONE_LIMIT) begin
      @(negedge clk_mem);
      if (done_mat_mul) begin
        seen = 1'b1;
      end else begin
        latency++;
      end
    end
    assert (seen) else begin
      $display("done_mat_mul never rose within %0d cycles of start", DONE_LIMIT);
      errors++;
    end
    run_active = 1'b0;
  endtask

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // Row i of C with each sum kept modulo 256
  function automatic mm_pkg::vector_t expected_row(input int i);
    mm_pkg::vector_t row;
    int              sum;
    for (int j = 0; j < N; j++) begin
      sum = 0;
      for (int k = 0; k < N; k++) begin
        sum = (sum + int'(a_m[i][k]) * int'(b_m[k][j])) % 256;
      end
      row[j] = 8'(sum);
    end
    return row;
  endfunction

  task automatic check_product(input string label);
    mm_pkg::vector_t got;
    mm_pkg::vector_t exp_word;
    for (int i = 0; i < N; i++) begin
      exp_word = expected_row(i);
      read_row(i, got);
      assert (got == exp_word) else begin
        $display("Mismatch: %s data_from_out_mat row %0d expected %h got %h",
                 label, i, exp_word, got);
        errors++;
      end
    end
  endtask

  task automatic randomize_a();
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        a_m[i][k] = 8'($random(seed));
      end
    end
  endtask

  task automatic randomize_b();
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        b_m[k][j] = 8'($random(seed));
      end
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic idle_after_reset();
    mm_pkg::vector_t got;
    @(negedge clk_mem);
    assert (done_mat_mul == 1'b0) else begin
      $display("Mismatch: done_mat_mul after reset expected 0 got %h", done_mat_mul);
      errors++;
    end
    for (int i = 0; i < N; i++) begin
      read_row(i, got);
      assert (got == '0) else begin
        $display("Mismatch: data_from_out_mat row %0d after reset expected %h got %h",
                 i, 32'h0, got);
        errors++;
      end
    end
  endtask

  task automatic identity_product();
    mm_pkg::vector_t got;
    int              latency;
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        a_m[i][k] = (i == k) ? 8'h01 : 8'h00;
      end
    end
    randomize_b();
    load_a();
    load_b();
    run_multiply(latency);
    // C equals B when A is the identity
    for (int i = 0; i < N; i++) begin
      read_row(i, got);
      for (int j = 0; j < N; j++) begin
        assert (got[j] == b_m[i][j]) else begin
          $display("Mismatch: identity data_from_out_mat[%0d][%0d] expected %h got %h",
                   i, j, b_m[i][j], got[j]);
          errors++;
        end
      end
    end
  endtask

  task automatic done_latency();
    int latency;
    run_multiply(latency);
    assert (latency == RUN_LATENCY) else begin
      $display("Mismatch: done_mat_mul latency expected %h got %h", RUN_LATENCY, latency);
      errors++;
    end
    @(negedge clk_mem);
    assert (done_mat_mul == 1'b0) else begin
      $display("Mismatch: done_mat_mul one cycle after done expected 0 got %h",
               done_mat_mul);
      errors++;
    end
    check_product("latency");
  endtask

  task automatic random_products();
    int latency;
    for (int t = 0; t < 3; t++) begin
      randomize_a();
      randomize_b();
      load_a();
      load_b();
      run_multiply(latency);
      check_product("random");
    end
    // All elements 0xff so every sum wraps
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        a_m[i][k] = 8'hff;
        b_m[i][k] = 8'hff;
      end
    end
    load_a();
    load_b();
    run_multiply(latency);
    check_product("full range");
  endtask

  task automatic back_to_back_runs();
    int latency;
    randomize_a();
    randomize_b();
    load_a();
    load_b();
    run_multiply(latency);
    check_product("first run");
    run_multiply(latency);
    check_product("repeat run");
    // Reload only B so stale sums would show up
    randomize_b();
    load_b();
    run_multiply(latency);
    check_product("reloaded b");
  endtask

  initial begin
    reset                   <= 1'b1;
    enable_writing_to_mem   <= 1'b0;
    enable_reading_from_mem <= 1'b0;
    we_a                    <= 1'b0;
    we_b                    <= 1'b0;
    addr_pi                 <= '0;
    data_pi                 <= '0;
    start_mat_mul           <= 1'b0;
    repeat (5) @(posedge clk_mem);
    reset <= 1'b0;

    idle_after_reset();
    identity_product();
    done_latency();
    random_products();
    back_to_back_runs();

    $display("Errors: %0d, cycles: %0d", errors, cycle_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
